// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --timing --assert
TOP        ?= ulpi_tb
RTL_TOP    ?= ulpi_link_top
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell sed -e '/^+/d' $(FILELIST)) ulpi_config.svh $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+.
ulpi_pkg.sv
link_pkg.sv
ulpi_wb_front.sv
ulpi_bus_ctrl.sv
ulpi_reg_write.sv
ulpi_reg_read.sv
ulpi_link_top.sv
tb_clock_gen.sv
ulpi_phy_model.sv
ulpi_checker.sv
ulpi_tb.sv

// File: link_pkg.sv
/*
 * Link-side types
 * Register requests from the host stage and controller states
 */
`include "ulpi_config.svh"

package link_pkg;

    typedef enum logic {
        OP_REG_WRITE,
        OP_REG_READ
    } link_op_e;

    // Held by the front until done comes back
    typedef struct packed {
        logic                    valid;
        link_op_e                op;
        logic [`ULPI_ADDR_W-1:0] addr;
        logic [`ULPI_DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                    done;  // One cycle, ends the request
        logic [`ULPI_DATA_W-1:0] rdata; // Meaningful for reads only
    } reg_rsp_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_REG_WRITE,
        CTRL_REG_READ,
        CTRL_RECV // PHY owns the bus
    } ctrl_state_e;

endpackage

// File: tb_clock_gen.sv
/*
 * Testbench clock and reset, 100 ns period, reset held for 10 cycles
 */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0; // Released off the edge like all other stimulus
    end

endmodule

// File: ulpi_bus_ctrl.sv
/*
 * ULPI bus controller
 * Arbitrates host requests against PHY turnarounds, retries aborted commands
 */
`timescale 1ns/10ps
`include "ulpi_config.svh"

module ulpi_bus_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  link_pkg::reg_req_t      req,
    output link_pkg::reg_rsp_t      rsp,
    output logic                    rxcmd_valid,
    output logic [`ULPI_DATA_W-1:0] rxcmd,
    input  ulpi_pkg::ulpi_rx_t      rx,
    output ulpi_pkg::ulpi_tx_t      tx,
    output logic                    wr_start,
    output logic                    rd_start,
    input  ulpi_pkg::ulpi_tx_t      wr_tx,
    input  ulpi_pkg::ulpi_tx_t      rd_tx,
    input  logic                    wr_done,
    input  logic                    rd_done,
    input  logic                    wr_abort,
    input  logic                    rd_abort,
    input  logic [`ULPI_DATA_W-1:0] rd_data
);

    link_pkg::ctrl_state_e state;
    logic                  dir_q;     // dir of the previous cycle
    logic                  can_issue;
    logic                  rx_byte;   // RX CMD byte on the pins, turnaround skipped

    // PHY wins over the host, so dir blocks a start
    assign can_issue = (state == link_pkg::CTRL_IDLE) && !rx.dir && req.valid;
    assign wr_start  = can_issue && (req.op == link_pkg::OP_REG_WRITE);
    assign rd_start  = can_issue && (req.op == link_pkg::OP_REG_READ);

    assign rx_byte = (state == link_pkg::CTRL_RECV) && rx.dir && !rx.nxt && dir_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= link_pkg::CTRL_IDLE;
            dir_q       <= 1'b0;
            rxcmd_valid <= 1'b0;
        end else begin
            dir_q       <= rx.dir;
            rxcmd_valid <= rx_byte;
            case (state)
                link_pkg::CTRL_IDLE: begin
                    if (rx.dir)
                        state <= link_pkg::CTRL_RECV;      // PHY turnaround
                    else if (wr_start)
                        state <= link_pkg::CTRL_REG_WRITE;
                    else if (rd_start)
                        state <= link_pkg::CTRL_REG_READ;
                end
                link_pkg::CTRL_REG_WRITE: begin
                    if (wr_abort)
                        state <= link_pkg::CTRL_RECV; // req stays valid, reissued from idle
                    else if (wr_done)
                        state <= link_pkg::CTRL_IDLE;
                end
                link_pkg::CTRL_REG_READ: begin
                    if (rd_abort)
                        state <= link_pkg::CTRL_RECV;
                    else if (rd_done)
                        state <= link_pkg::CTRL_IDLE;
                end
                link_pkg::CTRL_RECV: begin
                    if (!rx.dir)
                        state <= link_pkg::CTRL_IDLE;
                end
                default: state <= link_pkg::CTRL_IDLE;
            endcase
        end
    end

    // Captured byte, qualified by rxcmd_valid
    always_ff @(posedge clk) begin
        if (rx_byte)
            rxcmd <= rx.data;
    end

    // Only the owning sequencer reaches the pins
    always_comb begin
        case (state)
            link_pkg::CTRL_REG_WRITE: tx = wr_tx;
            link_pkg::CTRL_REG_READ:  tx = rd_tx;
            default:                  tx = '0;
        endcase
    end

    // Same cycle as done, so the front never sees a stale valid in idle
    always_comb begin
        rsp.done  = ((state == link_pkg::CTRL_REG_WRITE) && wr_done) ||
                    ((state == link_pkg::CTRL_REG_READ) && rd_done);
        rsp.rdata = rd_data;
    end

endmodule

// File: ulpi_checker.sv
/*
 * Concurrent protocol assertions on the ULPI pins and Wishbone ack
 */
`timescale 1ns/10ps

module ulpi_checker (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic ulpi_dir,
    input logic ulpi_data_oe,
    input logic ulpi_stp
);

    // STP is a single-cycle marker
    stp_single: assert property (@(posedge clk) disable iff (rst) ulpi_stp |=> !ulpi_stp)
        else $error("ulpi_stp high for two cycles");

    // No drive right after the PHY owned the bus
    oe_after_dir: assert property (@(posedge clk) disable iff (rst)
        ulpi_dir |=> !ulpi_data_oe)
        else $error("ulpi_data_oe high after ulpi_dir");

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack outside a bus cycle");

    reset_values: assert property (@(posedge clk)
        $fell(rst) |-> (!wb_ack && !ulpi_stp && !ulpi_data_oe))
        else $error("outputs not quiet after reset");

endmodule

bind ulpi_link_top ulpi_checker ulpi_checker_inst (
    .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
    .ulpi_dir(ulpi_dir), .ulpi_data_oe(ulpi_data_oe), .ulpi_stp(ulpi_stp)
);

// File: ulpi_config.svh
/*
 * ULPI link widths and address map
 */
`ifndef ULPI_CONFIG_SVH
`define ULPI_CONFIG_SVH

// ULPI data bus and register data width
`define ULPI_DATA_W 8

// Immediate register address, 64 registers
`define ULPI_ADDR_W 6

// Host bus address width
`define WB_ADR_W 8

// Read-only byte holding the last RX CMD from the PHY
// Sits just above the PHY register window
`define LINK_STATUS_ADR 8'h40

`endif

// File: ulpi_link_top.sv
/*
 * ULPI link controller top
 * Wishbone front, bus controller and register sequencers
 */
`timescale 1ns/10ps
`include "ulpi_config.svh"

module ulpi_link_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`WB_ADR_W-1:0]    wb_adr,
    input  logic [`ULPI_DATA_W-1:0] wb_dat_w,
    output logic [`ULPI_DATA_W-1:0] wb_dat_r,
    output logic                    wb_ack,
    input  logic                    ulpi_dir,
    input  logic                    ulpi_nxt,
    input  logic [`ULPI_DATA_W-1:0] ulpi_data_in,
    output logic [`ULPI_DATA_W-1:0] ulpi_data_out,
    output logic                    ulpi_data_oe,
    output logic                    ulpi_stp
);

    link_pkg::reg_req_t      req;
    link_pkg::reg_rsp_t      rsp;
    ulpi_pkg::ulpi_rx_t      rx;
    ulpi_pkg::ulpi_tx_t      tx;
    ulpi_pkg::ulpi_tx_t      wr_tx;
    ulpi_pkg::ulpi_tx_t      rd_tx;
    logic                    rxcmd_valid;
    logic [`ULPI_DATA_W-1:0] rxcmd;
    logic                    wr_start;
    logic                    rd_start;
    logic                    wr_done;
    logic                    rd_done;
    logic                    wr_abort;
    logic                    rd_abort;
    logic [`ULPI_DATA_W-1:0] rd_data;

    // Pin bundles
    assign rx            = '{dir: ulpi_dir, nxt: ulpi_nxt, data: ulpi_data_in};
    assign ulpi_data_out = tx.data;
    assign ulpi_data_oe  = tx.oe;
    assign ulpi_stp      = tx.stp;

    ulpi_wb_front ulpi_wb_front_inst (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .req(req), .rsp(rsp), .rxcmd_valid(rxcmd_valid), .rxcmd(rxcmd)
    );

    ulpi_bus_ctrl ulpi_bus_ctrl_inst (
        .clk(clk), .rst(rst), .req(req), .rsp(rsp),
        .rxcmd_valid(rxcmd_valid), .rxcmd(rxcmd), .rx(rx), .tx(tx),
        .wr_start(wr_start), .rd_start(rd_start), .wr_tx(wr_tx), .rd_tx(rd_tx),
        .wr_done(wr_done), .rd_done(rd_done), .wr_abort(wr_abort),
        .rd_abort(rd_abort), .rd_data(rd_data)
    );

    // Address and data come straight from the held request
    ulpi_reg_write ulpi_reg_write_inst (
        .clk(clk), .rst(rst), .start(wr_start), .addr(req.addr), .wdata(req.wdata),
        .rx(rx), .tx(wr_tx), .done(wr_done), .abort(wr_abort)
    );

    ulpi_reg_read ulpi_reg_read_inst (
        .clk(clk), .rst(rst), .start(rd_start), .addr(req.addr), .rx(rx),
        .tx(rd_tx), .rdata(rd_data), .done(rd_done), .abort(rd_abort)
    );

endmodule

// File: ulpi_phy_model.sv
/*
 * Behavioral ULPI PHY with a 64-entry register file
 * Random NXT delay, RX CMD injection and abort of the next register write
 */
`timescale 1ns/10ps
`include "ulpi_config.svh"

module ulpi_phy_model (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`ULPI_DATA_W-1:0] data_out,
    input  logic                    data_oe,
    input  logic                    stp,
    output logic                    dir,
    output logic                    nxt,
    output logic [`ULPI_DATA_W-1:0] data_in
);

    logic [`ULPI_DATA_W-1:0] regs [0:63];
    bit                      abort_armed;  // Set by the testbench, cleared on use
    bit                      inject_pend;  // Set by the testbench, cleared when sent
    logic [`ULPI_DATA_W-1:0] inject_byte;

    // Outputs change 1 ns after the edge, link outputs are stable then
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic nxt_wait();
        int d;
        d = $urandom_range(3, 0);
        repeat (d) step();
    endtask

    // Turnaround, one byte, hand back
    task automatic send_rx_byte(input logic [`ULPI_DATA_W-1:0] b);
        dir = 1'b1;
        step();
        data_in = b;
        step();
        dir     = 1'b0;
        data_in = '0;
    endtask

    task automatic serve_write(input logic [5:0] a);
        logic [`ULPI_DATA_W-1:0] wd;
        nxt_wait();
        nxt = 1'b1;  // Accept TX CMD
        step();
        nxt = 1'b0;
        nxt_wait();
        wd  = data_out;
        nxt = 1'b1;  // Accept data byte
        step();
        nxt = 1'b0;
        if (stp)
            regs[a] = wd;
    endtask

    task automatic serve_read(input logic [5:0] a);
        nxt_wait();
        nxt = 1'b1;
        step();
        nxt = 1'b0;
        dir = 1'b1;  // Turnaround cycle
        step();
        data_in = regs[a];
        step();
        dir     = 1'b0;
        data_in = '0;
    endtask

    initial begin
        dir         = 1'b0;
        nxt         = 1'b0;
        data_in     = '0;
        abort_armed = 1'b0;
        inject_pend = 1'b0;
        inject_byte = '0;
        for (int i = 0; i < 64; i++)
            regs[i] = 8'(i) ^ 8'hA5;  // Reset contents
        forever begin
            step();
            if (!rst && data_oe && data_out[7:6] == ulpi_pkg::CMD_REG_WRITE) begin
                if (abort_armed) begin
                    abort_armed = 1'b0;
                    send_rx_byte(8'h4C);  // Steals the bus mid command
                end else begin
                    serve_write(data_out[5:0]);
                end
            end else if (!rst && data_oe && data_out[7:6] == ulpi_pkg::CMD_REG_READ) begin
                serve_read(data_out[5:0]);
            end else if (!rst && inject_pend) begin
                send_rx_byte(inject_byte);
                step();
                inject_pend = 1'b0;
            end
        end
    end

endmodule

// File: ulpi_pkg.sv
/*
 * ULPI pin-level types
 * TX CMD opcodes and the bundles driven by each side of the bus
 */
`include "ulpi_config.svh"

package ulpi_pkg;

    // Top two bits of a TX CMD byte
    typedef enum logic [1:0] {
        CMD_SPECIAL   = 2'b00, // NOOPID and friends
        CMD_TRANSMIT  = 2'b01, // Packet transmit, unused here
        CMD_REG_WRITE = 2'b10,
        CMD_REG_READ  = 2'b11
    } ulpi_cmd_e;

    // Link side of the bus
    typedef struct packed {
        logic [`ULPI_DATA_W-1:0] data; // Valid only with oe
        logic                    oe;   // Link owns data pins
        logic                    stp;  // End of link transfer
    } ulpi_tx_t;

    // PHY side of the bus
    typedef struct packed {
        logic                    dir;  // PHY owns data pins
        logic                    nxt;  // PHY throttle
        logic [`ULPI_DATA_W-1:0] data;
    } ulpi_rx_t;

endpackage

// File: ulpi_reg_read.sv
/*
 * ULPI register read sequencer
 * TX CMD until NXT, bus turnaround, data capture, wait for the PHY to release
 */
`timescale 1ns/10ps
`include "ulpi_config.svh"

module ulpi_reg_read (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [`ULPI_ADDR_W-1:0] addr,
    input  ulpi_pkg::ulpi_rx_t      rx,
    output ulpi_pkg::ulpi_tx_t      tx,
    output logic [`ULPI_DATA_W-1:0] rdata,
    output logic                    done,
    output logic                    abort
);

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_CMD,  // TX CMD on the bus
        RD_TURN, // dir rising, nobody drives
        RD_CAPT, // Register data from the PHY
        RD_WAIT  // PHY hands the bus back
    } rd_state_e;

    rd_state_e state;

    assign abort = (state == RD_CMD) && rx.dir;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RD_IDLE;
            tx    <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                RD_IDLE: begin
                    if (start) begin
                        tx.data <= {ulpi_pkg::CMD_REG_READ, addr};
                        tx.oe   <= 1'b1;
                        tx.stp  <= 1'b0;
                        state   <= RD_CMD;
                    end
                end
                RD_CMD: begin
                    if (rx.dir) begin
                        tx    <= '0;
                        state <= RD_IDLE;
                    end else if (rx.nxt) begin
                        tx    <= '0; // Release for turnaround
                        state <= RD_TURN;
                    end
                end
                RD_TURN: state <= RD_CAPT;
                RD_CAPT: state <= RD_WAIT;
                RD_WAIT: begin
                    if (!rx.dir) begin
                        done  <= 1'b1;
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Data byte follows the turnaround cycle
    always_ff @(posedge clk) begin
        if (state == RD_CAPT)
            rdata <= rx.data;
    end

endmodule

// File: ulpi_reg_write.sv
/*
 * ULPI register write sequencer
 * TX CMD, data byte, then one STP cycle, each paced by NXT
 */
`timescale 1ns/10ps
`include "ulpi_config.svh"

module ulpi_reg_write (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [`ULPI_ADDR_W-1:0] addr,
    input  logic [`ULPI_DATA_W-1:0] wdata,
    input  ulpi_pkg::ulpi_rx_t      rx,
    output ulpi_pkg::ulpi_tx_t      tx,
    output logic                    done,
    output logic                    abort
);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_CMD,  // TX CMD on the bus
        WR_DATA, // Register data on the bus
        WR_STP
    } wr_state_e;

    wr_state_e state;

    // PHY took the bus before accepting the command
    assign abort = (state == WR_CMD) && rx.dir;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WR_IDLE;
            tx    <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                WR_IDLE: begin
                    if (start) begin
                        tx.data <= {ulpi_pkg::CMD_REG_WRITE, addr};
                        tx.oe   <= 1'b1;
                        tx.stp  <= 1'b0;
                        state   <= WR_CMD;
                    end
                end
                WR_CMD: begin
                    if (rx.dir) begin
                        tx    <= '0; // Release at once
                        state <= WR_IDLE;
                    end else if (rx.nxt) begin
                        tx.data <= wdata;
                        state   <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (rx.nxt) begin
                        tx.data <= '0;
                        tx.stp  <= 1'b1;
                        done    <= 1'b1; // Lines up with the STP cycle
                        state   <= WR_STP;
                    end
                end
                WR_STP: begin
                    tx    <= '0;
                    state <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

endmodule

// File: ulpi_tb.sv
/*
 * ULPI link testbench
 * Table-driven Wishbone traffic against a behavioral PHY
 */
`timescale 1ns/10ps
`include "ulpi_config.svh"

module ulpi_tb;

    typedef enum logic [1:0] {
        STEP_WB_WRITE,
        STEP_WB_READ,
        STEP_INJECT_RXCMD,
        STEP_ARM_ABORT
    } step_kind_e;

    typedef struct packed {
        step_kind_e kind;
        logic [7:0] adr;
        logic [7:0] dat;
        logic [7:0] exp; // Expected read data
    } step_row_t;

    localparam int WAIT_LIMIT = 200; // Cycles per wait loop

    logic       clk, rst;
    logic       wb_cyc, wb_stb, wb_we, wb_ack;
    logic [7:0] wb_adr, wb_dat_w, wb_dat_r;
    logic       ulpi_dir, ulpi_nxt, ulpi_data_oe, ulpi_stp;
    logic [7:0] ulpi_data_in, ulpi_data_out;
    step_row_t  table_q[$];
    logic [7:0] shadow [0:63]; // Expected PHY register contents

    tb_clock_gen tb_clock_gen_inst (.clk(clk), .rst(rst));

    ulpi_link_top ulpi_link_top_inst (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .ulpi_dir(ulpi_dir), .ulpi_nxt(ulpi_nxt), .ulpi_data_in(ulpi_data_in),
        .ulpi_data_out(ulpi_data_out), .ulpi_data_oe(ulpi_data_oe), .ulpi_stp(ulpi_stp)
    );

    ulpi_phy_model phy_model_inst (
        .clk(clk), .rst(rst), .data_out(ulpi_data_out), .data_oe(ulpi_data_oe),
        .stp(ulpi_stp), .dir(ulpi_dir), .nxt(ulpi_nxt), .data_in(ulpi_data_in)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic add_row(input step_kind_e kind, input logic [7:0] adr,
                           input logic [7:0] dat, input logic [7:0] exp);
        table_q.push_back('{kind: kind, adr: adr, dat: dat, exp: exp});
    endtask

    // Classic cycle held until ack and dropped the cycle after it
    task automatic wb_cycle(input logic we, input logic [7:0] adr, input logic [7:0] dat,
                            output logic [7:0] rdata);
        int n;
        n        = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        while (!wb_ack) begin
            next_cycle();
            n++;
            if (n > WAIT_LIMIT)
                report_failure($sformatf("no Wishbone ack for address 0x%02h", adr));
        end
        rdata = wb_dat_r;
        next_cycle();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
        if (adr[7:6] == 2'b00) begin // PHY register window
            shadow[adr[5:0]] = dat;
            check_value("phy_regs", phy_model_inst.regs[adr[5:0]], dat);
        end
    endtask

    task automatic wb_read(input logic [7:0] adr, input logic [7:0] exp);
        logic [7:0] got;
        wb_cycle(1'b0, adr, 8'h00, got);
        check_value("wb_dat_r", got, exp);
    endtask

    task automatic inject_rxcmd(input logic [7:0] b);
        int n;
        n = 0;
        phy_model_inst.inject_byte = b;
        phy_model_inst.inject_pend = 1'b1;
        while (phy_model_inst.inject_pend) begin
            next_cycle();
            n++;
            if (n > WAIT_LIMIT)
                report_failure("PHY model never sent the RX CMD byte");
        end
    endtask

    task automatic apply_row(input step_row_t row);
        case (row.kind)
            STEP_WB_WRITE: begin
                wb_write(row.adr, row.dat);
                // An armed abort must hit the write that follows it
                if (phy_model_inst.abort_armed)
                    report_failure("armed abort was not taken by the PHY model");
            end
            STEP_WB_READ:      wb_read(row.adr, row.exp);
            STEP_INJECT_RXCMD: inject_rxcmd(row.dat);
            default:           phy_model_inst.abort_armed = 1'b1;
        endcase
    endtask

    initial begin
        logic [31:0] r;
        int          n;
        void'($urandom(23292));
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int i = 0; i < 64; i++)
            shadow[i] = 8'(i) ^ 8'hA5;

        add_row(STEP_WB_WRITE,     8'h05, 8'h3C, 8'h00);
        add_row(STEP_WB_READ,      8'h05, 8'h00, 8'h3C);
        add_row(STEP_WB_READ,      8'h12, 8'h00, 8'hB7); // Reset contents 0x12 ^ 0xA5
        add_row(STEP_INJECT_RXCMD, 8'h00, 8'h4E, 8'h00);
        add_row(STEP_WB_READ,      `LINK_STATUS_ADR, 8'h00, 8'h4E);
        add_row(STEP_INJECT_RXCMD, 8'h00, 8'h91, 8'h00);
        add_row(STEP_WB_READ,      `LINK_STATUS_ADR, 8'h00, 8'h91);
        add_row(STEP_ARM_ABORT,    8'h00, 8'h00, 8'h00);
        add_row(STEP_WB_WRITE,     8'h2A, 8'h77, 8'h00); // Aborted once and then retried
        add_row(STEP_WB_READ,      8'h2A, 8'h00, 8'h77);
        add_row(STEP_WB_READ,      8'h80, 8'h00, 8'h00);
        add_row(STEP_WB_READ,      8'h7F, 8'h00, 8'h00);
        add_row(STEP_INJECT_RXCMD, 8'h00, 8'h33, 8'h00);
        add_row(STEP_WB_WRITE,     `LINK_STATUS_ADR, 8'hFF, 8'h00); // Status is read-only
        add_row(STEP_WB_READ,      `LINK_STATUS_ADR, 8'h00, 8'h33);

        n = 0;
        next_cycle();
        while (rst) begin
            next_cycle();
            n++;
            if (n > WAIT_LIMIT)
                report_failure("reset never released");
        end
        repeat (2) next_cycle();

        foreach (table_q[i])
            apply_row(table_q[i]);

        // Random traffic against the shadow registers
        for (int i = 0; i < 40; i++) begin
            r = $urandom;
            if (r[16])
                wb_write({2'b00, r[5:0]}, r[15:8]);
            else
                wb_read({2'b00, r[5:0]}, shadow[r[5:0]]);
        end

        repeat (3) next_cycle();
        $display("Verification passed");
        $finish;
    end

endmodule

// File: ulpi_wb_front.sv
/*
 * Wishbone classic slave front end of the ULPI link
 * Turns bus cycles into register requests, serves the RX CMD status locally
 */
`timescale 1ns/10ps
`include "ulpi_config.svh"

module ulpi_wb_front (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`WB_ADR_W-1:0]    wb_adr,
    input  logic [`ULPI_DATA_W-1:0] wb_dat_w,
    output logic [`ULPI_DATA_W-1:0] wb_dat_r,
    output logic                    wb_ack,
    output link_pkg::reg_req_t      req,
    input  link_pkg::reg_rsp_t      rsp,
    input  logic                    rxcmd_valid,
    input  logic [`ULPI_DATA_W-1:0] rxcmd
);

    logic                    active;     // Cycle accepted, reply pending
    logic                    local_pend; // Reply served here, ack next cycle
    logic [`ULPI_DATA_W-1:0] status_q;   // Last RX CMD byte
    logic                    is_phy;
    logic                    is_status;

    // PHY window needs the bits above the register address clear
    assign is_phy    = (wb_adr[`WB_ADR_W-1:`ULPI_ADDR_W] == '0);
    assign is_status = (wb_adr == `LINK_STATUS_ADR);

    always_ff @(posedge clk) begin
        if (rst) begin
            active     <= 1'b0;
            local_pend <= 1'b0;
            status_q   <= '0;
            req        <= '0;
            wb_ack     <= 1'b0;
            wb_dat_r   <= '0;
        end else begin
            wb_ack <= 1'b0; // Single-cycle pulse
            if (rxcmd_valid)
                status_q <= rxcmd;

            // Ack cycle still has stb high, so skip it
            if (wb_cyc && wb_stb && !active && !wb_ack) begin
                active <= 1'b1;
                if (is_phy) begin
                    req.valid <= 1'b1;
                    req.op    <= wb_we ? link_pkg::OP_REG_WRITE : link_pkg::OP_REG_READ;
                    req.addr  <= wb_adr[`ULPI_ADDR_W-1:0];
                    req.wdata <= wb_dat_w;
                end else begin
                    local_pend <= 1'b1;
                    // Status writes and unmapped accesses have no effect
                    wb_dat_r   <= (is_status && !wb_we) ? status_q : '0;
                end
            end

            if (local_pend) begin
                local_pend <= 1'b0;
                wb_ack     <= 1'b1;
                active     <= 1'b0;
            end

            if (rsp.done) begin
                req.valid <= 1'b0; // Drops the cycle after done
                wb_ack    <= 1'b1;
                wb_dat_r  <= rsp.rdata;
                active    <= 1'b0;
            end
        end
    end

endmodule
